// ==== Makefile ====
# Verilator build and run of the vc router testbench

LOG = sim.log

help:
	@echo "make test   build with Verilator, run, and check the log for the pass line"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		-f sources.f --top-module tb_vc_router -Mdir obj_dir -o sim_vc_router
	./obj_dir/sim_vc_router | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: help test clean

// ==== source/lookahead_route.sv ====
// lookahead route: xy direction the flit takes at the neighbor behind one output
`default_nettype none

module lookahead_route import noc_pkg::*; #(
  parameter int         RouterX = 0,
  parameter int         RouterY = 0,
  parameter route_dir_e Dir     = Local
) (
  input  logic [CoordW-1:0] dst_x_i,
  input  logic [CoordW-1:0] dst_y_i,
  output route_dir_e        next_dir_o
);

  // coordinates of the router reached through this output
  // north raises y, east raises x
  localparam int NextX = (Dir == East) ? RouterX + 1 :
                         (Dir == West) ? RouterX - 1 : RouterX;
  localparam int NextY = (Dir == North) ? RouterY + 1 :
                         (Dir == South) ? RouterY - 1 : RouterY;

  // x first, then y
  always_comb begin
    if (Dir == Local) begin
      // ejected here, nothing further to route
      next_dir_o = Local;
    end else if (int'(dst_x_i) > NextX) begin
      next_dir_o = East;
    end else if (int'(dst_x_i) < NextX) begin
      next_dir_o = West;
    end else if (int'(dst_y_i) > NextY) begin
      next_dir_o = North;
    end else if (int'(dst_y_i) < NextY) begin
      next_dir_o = South;
    end else begin
      next_dir_o = Local;
    end
  end

endmodule

`default_nettype wire

// ==== source/noc_pkg.sv ====
// noc package: route directions, flit header and flit types, default router sizes
`default_nettype none

package noc_pkg;

  // default sizes handed down from the router top
  localparam int unsigned NumPortsDef  = 5;
  localparam int unsigned NumVCDef     = 2;
  localparam int unsigned FifoDepthDef = 4;

  // width of one mesh coordinate
  localparam int unsigned CoordW = 4;

  // output directions, value doubles as the bit index of a one-hot request
  typedef enum logic [2:0] {
    Local = 3'd0,
    North = 3'd1,
    East  = 3'd2,
    South = 3'd3,
    West  = 3'd4
  } route_dir_e;

  // flit header, 11 bits
  // lookahead is the direction to take at the router that receives the flit
  typedef struct packed {
    logic [CoordW-1:0] dst_x;
    logic [CoordW-1:0] dst_y;
    route_dir_e        lookahead;
  } hdr_t;

  // every flit carries its own header, 43 bits in all
  typedef struct packed {
    hdr_t        hdr;
    logic [31:0] payload;
  } flit_t;

endpackage

`default_nettype wire

// ==== source/output_port.sv ====
// output port: global switch arbitration, crossbar mux, lookahead rewrite, output register
`default_nettype none

module output_port import noc_pkg::*; #(
  parameter int unsigned NumPorts = NumPortsDef,
  parameter int unsigned NumVC    = NumVCDef,
  parameter int          RouterX  = 0,
  parameter int          RouterY  = 0,
  parameter route_dir_e  Dir      = Local,
  localparam int unsigned VcIdW   = (NumVC > 1) ? $clog2(NumVC) : 1,
  localparam int unsigned PortIdW = (NumPorts > 1) ? $clog2(NumPorts) : 1
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  sa_req_if.arbiter        sa [NumPorts],
  output logic             flit_valid_o,
  output logic [VcIdW-1:0] flit_vc_o,
  output flit_t            flit_o
);

  logic [NumPorts-1:0] req;
  logic [NumPorts-1:0] grant;
  logic [PortIdW-1:0]  grant_id;
  logic                any_gnt;

  // requests flattened out of the interface array
  flit_t            in_flit [NumPorts];
  logic [VcIdW-1:0] in_vc [NumPorts];

  flit_t      next_flit;
  route_dir_e next_dir;

  // output register
  logic             valid_q;
  logic [VcIdW-1:0] vc_q;
  flit_t            flit_q;

  for (genvar i = 0; i < NumPorts; i++) begin : g_in
    // input i wants us when its one-hot request points at this direction
    assign req[i]     = sa[i].req_v & sa[i].req_dir_oh[Dir];
    assign in_flit[i] = sa[i].req_flit;
    assign in_vc[i]   = sa[i].req_vc;
    // our bit of input i's grant vector
    assign sa[i].gnt[Dir] = grant[i];
  end

  rr_arbiter #(
    .NumInputs (NumPorts)
  ) i_out_arb (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (req),
    .update_i   (any_gnt),
    .grant_o    (grant),
    .grant_id_o (grant_id)
  );

  assign any_gnt = |grant;

  // next hop direction for the winning destination
  lookahead_route #(
    .RouterX (RouterX),
    .RouterY (RouterY),
    .Dir     (Dir)
  ) i_la_route (
    .dst_x_i    (in_flit[grant_id].hdr.dst_x),
    .dst_y_i    (in_flit[grant_id].hdr.dst_y),
    .next_dir_o (next_dir)
  );

  // crossbar pick with the lookahead swapped in
  always_comb begin
    next_flit               = in_flit[grant_id];
    next_flit.hdr.lookahead = next_dir;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= any_gnt;
    end
  end

  // payload only loads on a grant
  always_ff @(posedge clk_i) begin
    if (any_gnt) begin
      flit_q <= next_flit;
      vc_q   <= in_vc[grant_id];
    end
  end

  assign flit_valid_o = valid_q;
  assign flit_vc_o    = vc_q;
  assign flit_o       = flit_q;

endmodule

`default_nettype wire

// ==== source/rr_arbiter.sv ====
// round-robin arbiter with one-hot and binary grant, pointer moves on an update strobe
`default_nettype none

module rr_arbiter #(
  parameter int unsigned NumInputs = 4,
  localparam int unsigned IdW      = (NumInputs > 1) ? $clog2(NumInputs) : 1
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [NumInputs-1:0] req_i,
  input  logic                 update_i,
  output logic [NumInputs-1:0] grant_o,
  output logic [IdW-1:0]       grant_id_o
);

  // index holding highest priority
  logic [IdW-1:0] ptr_q;
  logic           found;

  // scan from the pointer upward, wrapping, first requester wins
  always_comb begin
    int idx;
    grant_o    = '0;
    grant_id_o = '0;
    found      = 1'b0;
    idx        = 0;
    for (int i = 0; i < int'(NumInputs); i++) begin
      idx = (int'(ptr_q) + i) % int'(NumInputs);
      if (!found && req_i[idx]) begin
        found         = 1'b1;
        grant_o[idx]  = 1'b1;
        grant_id_o    = IdW'(idx);
      end
    end
  end

  // pointer goes one past the winner, only when something was granted
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (update_i && found) begin
      if (grant_id_o == IdW'(NumInputs - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= grant_id_o + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/sa_local.sv ====
// local switch allocator: picks one valid vc head and turns its lookahead into a request
`default_nettype none

module sa_local import noc_pkg::*; #(
  parameter int unsigned NumVC    = NumVCDef,
  parameter int unsigned NumPorts = NumPortsDef,
  localparam int unsigned VcIdW   = (NumVC > 1) ? $clog2(NumVC) : 1
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [NumVC-1:0]    vc_head_v_i,
  input  hdr_t [NumVC-1:0]    vc_head_i,
  input  logic                update_rr_arb_i,
  output logic                sa_local_v_o,
  output logic [VcIdW-1:0]    sa_local_vc_id_o,
  output logic [NumVC-1:0]    sa_local_vc_id_oh_o,
  output logic [NumPorts-1:0] sa_local_output_dir_oh_o
);

  // round robin over the valid vc heads
  rr_arbiter #(
    .NumInputs (NumVC)
  ) i_vc_arb (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (vc_head_v_i),
    .update_i   (update_rr_arb_i),
    .grant_o    (sa_local_vc_id_oh_o),
    .grant_id_o (sa_local_vc_id_o)
  );

  // any valid head means a vc gets chosen
  assign sa_local_v_o = |vc_head_v_i;

  // one bit at the chosen head's lookahead, all zero when idle
  always_comb begin
    sa_local_output_dir_oh_o = '0;
    sa_local_output_dir_oh_o[vc_head_i[sa_local_vc_id_o].lookahead] = sa_local_v_o;
  end

endmodule

`default_nettype wire

// ==== source/sa_req_if.sv ====
// switch request interface: one input port's request to all outputs and the grant back
`default_nettype none

interface sa_req_if import noc_pkg::*; #(
  parameter int unsigned NumVC    = NumVCDef,
  parameter int unsigned NumPorts = NumPortsDef,
  localparam int unsigned VcIdW   = (NumVC > 1) ? $clog2(NumVC) : 1
) ();

  // request side, held combinationally while the vc head is valid
  logic                req_v;
  logic [NumPorts-1:0] req_dir_oh;
  logic [VcIdW-1:0]    req_vc;
  flit_t               req_flit;

  // one bit per output, set by the output whose arbiter picked this input
  logic [NumPorts-1:0] gnt;

  modport requester (
    output req_v, req_dir_oh, req_vc, req_flit,
    input  gnt
  );

  // each output port drives only its own gnt bit
  modport arbiter (
    input  req_v, req_dir_oh, req_vc, req_flit,
    output gnt
  );

endinterface

`default_nettype wire

// ==== source/vc_input_port.sv ====
// input port: per-vc flit fifos, local allocation, pop on grant and credit return
`default_nettype none

module vc_input_port import noc_pkg::*; #(
  parameter int unsigned NumVC     = NumVCDef,
  parameter int unsigned NumPorts  = NumPortsDef,
  parameter int unsigned FifoDepth = FifoDepthDef,
  localparam int unsigned VcIdW    = (NumVC > 1) ? $clog2(NumVC) : 1
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             flit_valid_i,
  input  logic [VcIdW-1:0] flit_vc_i,
  input  flit_t            flit_i,
  output logic [NumVC-1:0] credit_o,
  sa_req_if.requester      sa
);

  localparam int unsigned PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  logic [NumVC-1:0] head_v;
  flit_t            head_flit [NumVC];
  hdr_t [NumVC-1:0] head_hdr;
  logic [NumVC-1:0] push;
  logic [NumVC-1:0] pop;

  // local allocator results
  logic                sel_v;
  logic [VcIdW-1:0]    sel_vc;
  logic [NumVC-1:0]    sel_vc_oh;
  logic [NumPorts-1:0] sel_dir_oh;
  logic                granted;

  // some output picked us this cycle
  assign granted = |sa.gnt;

  for (genvar v = 0; v < NumVC; v++) begin : g_vc
    flit_t            mem_q [FifoDepth];
    logic [PtrW-1:0] rd_ptr_q;
    logic [PtrW-1:0] wr_ptr_q;
    logic [CntW-1:0] cnt_q;

    assign push[v] = flit_valid_i && (flit_vc_i == VcIdW'(v));
    // only the vc chosen by the local arbiter can leave
    assign pop[v]  = granted && sel_vc_oh[v];

    assign head_v[v]    = (cnt_q != '0);
    assign head_flit[v] = mem_q[rd_ptr_q];
    assign head_hdr[v]  = mem_q[rd_ptr_q].hdr;

    // storage, no reset needed
    always_ff @(posedge clk_i) begin
      if (push[v]) begin
        mem_q[wr_ptr_q] <= flit_i;
      end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        rd_ptr_q <= '0;
        wr_ptr_q <= '0;
        cnt_q    <= '0;
      end else begin
        // circular pointers wrap at the depth
        if (push[v]) begin
          wr_ptr_q <= (wr_ptr_q == PtrW'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop[v]) begin
          rd_ptr_q <= (rd_ptr_q == PtrW'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        // push and pop together leave the count alone
        if (push[v] && !pop[v]) begin
          cnt_q <= cnt_q + 1'b1;
        end else if (pop[v] && !push[v]) begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

  sa_local #(
    .NumVC    (NumVC),
    .NumPorts (NumPorts)
  ) i_sa_local (
    .clk_i                    (clk_i),
    .rst_n_i                  (rst_n_i),
    .vc_head_v_i              (head_v),
    .vc_head_i                (head_hdr),
    .update_rr_arb_i          (granted),
    .sa_local_v_o             (sel_v),
    .sa_local_vc_id_o         (sel_vc),
    .sa_local_vc_id_oh_o      (sel_vc_oh),
    .sa_local_output_dir_oh_o (sel_dir_oh)
  );

  // request toward the output ports
  assign sa.req_v      = sel_v;
  assign sa.req_dir_oh = sel_dir_oh;
  assign sa.req_vc     = sel_vc;
  assign sa.req_flit   = head_flit[sel_vc];

  // one credit per popped flit, in the granted cycle
  assign credit_o = pop;

endmodule

`default_nettype wire

// ==== source/vc_router.sv ====
// virtual-channel mesh router core: five input ports joined to five output ports
`default_nettype none

module vc_router import noc_pkg::*; #(
  parameter int unsigned NumPorts  = NumPortsDef,
  parameter int unsigned NumVC     = NumVCDef,
  parameter int unsigned FifoDepth = FifoDepthDef,
  parameter int          RouterX   = 2,
  parameter int          RouterY   = 2,
  localparam int unsigned VcIdW    = (NumVC > 1) ? $clog2(NumVC) : 1
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  // upstream side, indexed by port
  input  logic [NumPorts-1:0]             flit_valid_i,
  input  logic [NumPorts-1:0][VcIdW-1:0]  flit_vc_i,
  input  flit_t [NumPorts-1:0]            flit_i,
  output logic [NumPorts-1:0][NumVC-1:0]  credit_o,
  // downstream side, always accepted
  output logic [NumPorts-1:0]             flit_valid_o,
  output logic [NumPorts-1:0][VcIdW-1:0]  flit_vc_o,
  output flit_t [NumPorts-1:0]            flit_o
);

  // one request bundle per input port
  sa_req_if #(
    .NumVC    (NumVC),
    .NumPorts (NumPorts)
  ) sa_if [NumPorts] ();

  for (genvar p = 0; p < NumPorts; p++) begin : g_port
    vc_input_port #(
      .NumVC     (NumVC),
      .NumPorts  (NumPorts),
      .FifoDepth (FifoDepth)
    ) i_in (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .flit_valid_i (flit_valid_i[p]),
      .flit_vc_i    (flit_vc_i[p]),
      .flit_i       (flit_i[p]),
      .credit_o     (credit_o[p]),
      .sa           (sa_if[p])
    );

    // port index is also the direction code
    output_port #(
      .NumPorts (NumPorts),
      .NumVC    (NumVC),
      .RouterX  (RouterX),
      .RouterY  (RouterY),
      .Dir      (route_dir_e'(p))
    ) i_out (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .sa           (sa_if),
      .flit_valid_o (flit_valid_o[p]),
      .flit_vc_o    (flit_vc_o[p]),
      .flit_o       (flit_o[p])
    );
  end

endmodule

`default_nettype wire

// ==== sources.f ====
source/noc_pkg.sv
source/sa_req_if.sv
source/rr_arbiter.sv
source/sa_local.sv
source/vc_input_port.sv
source/lookahead_route.sv
source/output_port.sv
source/vc_router.sv
tb/vc_router_sva.sv
tb/vc_router_checker.sv
tb/tb_vc_router.sv

// ==== tb/tb_vc_router.sv ====
// vc router testbench: lfsr traffic with credit tracking, then two inputs sharing one output
`default_nettype none

module tb_vc_router import noc_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumPorts  = NumPortsDef;
  localparam int NumVC     = NumVCDef;
  localparam int FifoDepth = FifoDepthDef;
  localparam int RouterX   = 2;
  localparam int RouterY   = 2;
  localparam int VcIdW     = (NumVC > 1) ? $clog2(NumVC) : 1;
  // random flits, then flits per input in the shared output phase
  localparam int NumRand   = 120;
  localparam int NumBurst  = 6;
  localparam int NumFlits  = NumRand + 2 * NumBurst;

  logic                           clk_i = 1'b0;
  logic                           rst_n_i;
  logic [NumPorts-1:0]            flit_valid_i;
  logic [NumPorts-1:0][VcIdW-1:0] flit_vc_i;
  flit_t [NumPorts-1:0]           flit_i;
  logic [NumPorts-1:0][NumVC-1:0] credit_o;
  logic [NumPorts-1:0]            flit_valid_o;
  logic [NumPorts-1:0][VcIdW-1:0] flit_vc_o;
  flit_t [NumPorts-1:0]           flit_o;

  logic [15:0] lfsr_q;
  int          credits [NumPorts][NumVC];
  int          sent;
  int          tb_errors;
  logic        shared_phase;
  int          chk_errors;
  int          chk_rx;
  int          chk_pending;

  always #50 clk_i = ~clk_i;

  vc_router #(
    .NumPorts  (NumPorts),
    .NumVC     (NumVC),
    .FifoDepth (FifoDepth),
    .RouterX   (RouterX),
    .RouterY   (RouterY)
  ) u_dut (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flit_valid_i (flit_valid_i),
    .flit_vc_i    (flit_vc_i),
    .flit_i       (flit_i),
    .credit_o     (credit_o),
    .flit_valid_o (flit_valid_o),
    .flit_vc_o    (flit_vc_o),
    .flit_o       (flit_o)
  );

  vc_router_checker #(
    .NumPorts (NumPorts),
    .NumVC    (NumVC),
    .RouterX  (RouterX),
    .RouterY  (RouterY)
  ) u_chk (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .in_valid_i     (flit_valid_i),
    .in_vc_i        (flit_vc_i),
    .in_flit_i      (flit_i),
    .credit_i       (credit_o),
    .out_valid_i    (flit_valid_o),
    .out_vc_i       (flit_vc_o),
    .out_flit_i     (flit_o),
    .shared_phase_i (shared_phase),
    .err_cnt_o      (chk_errors),
    .rx_cnt_o       (chk_rx),
    .pending_o      (chk_pending)
  );

  // 16-bit fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step for every bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  // xy route at this router, x first
  function automatic route_dir_e xy_dir(input int x, input int y, input int dx, input int dy);
    if (dx > x) return East;
    if (dx < x) return West;
    if (dy > y) return North;
    if (dy < y) return South;
    return Local;
  endfunction

  // upper payload nibble tags the source port
  task automatic make_flit(input int p, input int dx, input int dy, output flit_t f);
    logic [31:0] r;
    f.hdr.dst_x     = CoordW'(dx);
    f.hdr.dst_y     = CoordW'(dy);
    f.hdr.lookahead = xy_dir(RouterX, RouterY, dx, dy);
    rand_bits(28, r);
    f.payload = {4'(p), r[27:0]};
  endtask

  // falling edge: clear valids, count returned credits
  task automatic next_cycle();
    @(negedge clk_i);
    flit_valid_i = '0;
    for (int p = 0; p < NumPorts; p++) begin
      for (int v = 0; v < NumVC; v++) begin
        if (credit_o[p][v]) begin
          credits[p][v]++;
          if (credits[p][v] > FifoDepth) begin
            tb_errors++;
            $display("Error at %0t: port %0d vc %0d returned more credits than flits",
                     $time, p, v);
          end
        end
      end
    end
  endtask

  task automatic send(input int p, input int v, input flit_t f);
    flit_valid_i[p] = 1'b1;
    flit_vc_i[p]    = VcIdW'(v);
    flit_i[p]       = f;
    credits[p][v]--;
    sent++;
  endtask

  // every credit home and every flit seen at an output
  task automatic wait_idle();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      next_cycle();
      busy = (chk_pending != 0);
      for (int p = 0; p < NumPorts; p++) begin
        for (int v = 0; v < NumVC; v++) begin
          if (credits[p][v] != FifoDepth) busy = 1'b1;
        end
      end
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] dx;
    logic [31:0] dy;
    flit_t       f;
    int          b;
    flit_valid_i = '0;
    flit_vc_i    = '0;
    flit_i       = '0;
    rst_n_i      = 1'b0;
    lfsr_q       = 16'd64648;
    sent         = 0;
    tb_errors    = 0;
    shared_phase = 1'b0;
    for (int p = 0; p < NumPorts; p++) begin
      for (int v = 0; v < NumVC; v++) begin
        credits[p][v] = FifoDepth;
      end
    end
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;
    repeat (3) next_cycle();

    // random traffic, each port tries half the cycles on a random vc
    while (sent < NumRand) begin
      next_cycle();
      for (int p = 0; p < NumPorts; p++) begin
        rand_bits(2, r);
        if (r[0] && credits[p][int'(r[1])] > 0 && sent < NumRand) begin
          b = int'(r[1]);
          rand_bits(3, r);
          // now and then aim at this router itself
          if (r[2:0] == 3'd0) begin
            dx = RouterX;
            dy = RouterY;
          end else begin
            rand_bits(4, dx);
            rand_bits(4, dy);
          end
          make_flit(p, int'(dx), int'(dy), f);
          send(p, b, f);
        end
      end
    end
    wait_idle();

    // north and south inputs both stream into the east output
    shared_phase = 1'b1;
    b = 0;
    while (b < NumBurst) begin
      next_cycle();
      if (credits[int'(North)][0] > 0 && credits[int'(South)][0] > 0) begin
        make_flit(int'(North), 5, RouterY, f);
        send(int'(North), 0, f);
        make_flit(int'(South), 5, RouterY, f);
        send(int'(South), 0, f);
        b++;
      end
    end
    wait_idle();
    shared_phase = 1'b0;
    repeat (2) next_cycle();

    if (chk_rx != sent) begin
      tb_errors++;
      $display("Error at %0t: %0d flits sent but %0d received", $time, sent, chk_rx);
    end
    $display("flits sent %0d, received %0d, checker errors %0d, testbench errors %0d",
             sent, chk_rx, chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog, 40 cycles per flit
  initial begin
    #(NumFlits * 40 * 100);
    $display("Timeout: the router did not deliver all flits in time");
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/vc_router_checker.sv ====
// vc router checker: reference queues per input vc, compares every output flit and credit
`default_nettype none

module vc_router_checker import noc_pkg::*; #(
  parameter int NumPorts = 5,
  parameter int NumVC    = 2,
  parameter int RouterX  = 2,
  parameter int RouterY  = 2,
  localparam int VcIdW   = (NumVC > 1) ? $clog2(NumVC) : 1
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic [NumPorts-1:0]            in_valid_i,
  input  logic [NumPorts-1:0][VcIdW-1:0] in_vc_i,
  input  flit_t [NumPorts-1:0]           in_flit_i,
  input  logic [NumPorts-1:0][NumVC-1:0] credit_i,
  input  logic [NumPorts-1:0]            out_valid_i,
  input  logic [NumPorts-1:0][VcIdW-1:0] out_vc_i,
  input  flit_t [NumPorts-1:0]           out_flit_i,
  input  logic                           shared_phase_i,
  output int                             err_cnt_o,
  output int                             rx_cnt_o,
  output int                             pending_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // flits in flight, one queue per input port and vc
  flit_t ref_q [NumPorts*NumVC][$];
  int    last_src;
  logic  seen_in;

  // credits of the cycle before, and the input vcs whose flits now sit in outputs
  logic [NumPorts-1:0][NumVC-1:0] credit_q;
  logic [NumPorts-1:0][NumVC-1:0] popped;

  // lookahead for the neighbor behind output dir
  function automatic route_dir_e expected_lookahead(input int dir, input int dx, input int dy);
    int nx;
    int ny;
    nx = RouterX + ((dir == int'(East)) ? 1 : (dir == int'(West)) ? -1 : 0);
    ny = RouterY + ((dir == int'(North)) ? 1 : (dir == int'(South)) ? -1 : 0);
    if (dir == int'(Local)) return Local;
    if (dx > nx) return East;
    if (dx < nx) return West;
    if (dy > ny) return North;
    if (dy < ny) return South;
    return Local;
  endfunction

  task automatic check_out(input int o);
    flit_t got;
    flit_t exp;
    int    src;
    int    q;
    got = out_flit_i[o];
    src = int'(got.payload[31:28]);
    q   = src * NumVC + int'(out_vc_i[o]);
    rx_cnt_o++;
    // this flit left input src on its vc one cycle ago
    if (src < NumPorts) begin
      popped[src][out_vc_i[o]] = 1'b1;
    end
    if (src >= NumPorts || ref_q[q].size() == 0) begin
      err_cnt_o++;
      $display("Error at %0t: output %0d sent flit %h that no input holds", $time, o, got);
      return;
    end
    // oldest flit of that vc must come first
    exp = ref_q[q].pop_front();
    if (o != int'(exp.hdr.lookahead) || got.payload != exp.payload ||
        got.hdr.dst_x != exp.hdr.dst_x || got.hdr.dst_y != exp.hdr.dst_y ||
        got.hdr.lookahead != expected_lookahead(o, int'(exp.hdr.dst_x),
                                                int'(exp.hdr.dst_y))) begin
      err_cnt_o++;
      $display("Error at %0t: output %0d got %h, expected %h with next lookahead %0d",
               $time, o, got, exp, expected_lookahead(o, int'(exp.hdr.dst_x),
                                                      int'(exp.hdr.dst_y)));
    end
    // two busy inputs share east in turn
    if (shared_phase_i && o == int'(East)) begin
      if (src == last_src) begin
        err_cnt_o++;
        $display("Error at %0t: east output served input %0d twice in a row", $time, src);
      end
      last_src = src;
    end
  endtask

  initial begin
    err_cnt_o = 0;
    rx_cnt_o  = 0;
    pending_o = 0;
  end

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      seen_in  = 1'b0;
      last_src = -1;
      credit_q = '0;
    end else begin
      if (!shared_phase_i) last_src = -1;
      // router must stay quiet until fed
      if (!seen_in && (out_valid_i != '0 || credit_i != '0)) begin
        err_cnt_o++;
        $display("Error at %0t: output or credit active before any flit was sent", $time);
      end
      popped = '0;
      for (int o = 0; o < NumPorts; o++) begin
        if (out_valid_i[o]) check_out(o);
      end
      // a credit pulses in the cycle its flit is loaded into an output register
      if (popped != credit_q) begin
        err_cnt_o++;
        $display("Error at %0t: credits %b in the last cycle, but flits left from %b",
                 $time, credit_q, popped);
      end
      credit_q = credit_i;
      for (int p = 0; p < NumPorts; p++) begin
        if (in_valid_i[p]) begin
          ref_q[p*NumVC + int'(in_vc_i[p])].push_back(in_flit_i[p]);
          seen_in = 1'b1;
        end
      end
      pending_o = 0;
      for (int i = 0; i < NumPorts * NumVC; i++) begin
        pending_o += ref_q[i].size();
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/vc_router_sva.sv ====
// vc router assertions: one-hot grants, quiet outputs in reset, credits from occupied fifos
`default_nettype none

module vc_router_sva #(
  parameter int NumPorts = 5,
  parameter int NumVC    = 2
) (
  input logic                              clk_i,
  input logic                              rst_n_i,
  input logic [NumPorts-1:0][NumPorts-1:0] gnt_i,
  input logic [NumPorts-1:0][NumVC-1:0]    head_v_i,
  input logic [NumPorts-1:0][NumVC-1:0]    credit_i,
  input logic [NumPorts-1:0]               out_valid_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // an input is taken by one output at most
  for (genvar p = 0; p < NumPorts; p++) begin : g_gnt
    a_gnt_onehot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(gnt_i[p]))
      else $error("grant vector of input %0d has more than one bit set", p);
  end

  a_reset_quiet : assert property (@(posedge clk_i)
    !rst_n_i |-> (out_valid_i == '0 && credit_i == '0))
    else $error("output valid or credit high during reset");

  // a credit pulse pops a real flit
  a_credit_nonempty : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (credit_i & ~head_v_i) == '0)
    else $error("credit returned from an empty fifo");

endmodule

bind vc_router vc_router_sva #(
  .NumPorts (NumPorts),
  .NumVC    (NumVC)
) u_sva (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .gnt_i       ({sa_if[4].gnt, sa_if[3].gnt, sa_if[2].gnt, sa_if[1].gnt, sa_if[0].gnt}),
  .head_v_i    ({g_port[4].i_in.head_v, g_port[3].i_in.head_v, g_port[2].i_in.head_v,
                 g_port[1].i_in.head_v, g_port[0].i_in.head_v}),
  .credit_i    (credit_o),
  .out_valid_i (flit_valid_o)
);

`default_nettype wire
